//--- src/core_region_pkg.sv
//////////////////////////////////////////////////
// Payloads of the core region boundary channels
// Addresses count 16-byte memory lines, not bytes
//////////////////////////////////////////////////
package core_region_pkg;

  localparam int DATA_W   = 128;
  localparam int STRB_W   = DATA_W / 8;
  localparam int LINE_AW  = 12;
  localparam int BC_OFF_W = 9;

  // DMA write beat, one full line with byte strobes
  typedef struct packed {
    logic [LINE_AW-1:0] addr;
    logic [DATA_W-1:0]  data;
    logic [STRB_W-1:0]  strb;
    logic               last;
  } dma_wr_cmd_t;

  typedef struct packed {
    logic [LINE_AW-1:0] addr;
    logic               last;
  } dma_rd_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } dma_rd_resp_t;

  // Packet descriptor, slot in the low byte
  typedef struct packed {
    logic [35:0] tag;
    logic [3:0]  port;
    logic [15:0] len;
    logic [7:0]  slot;
  } desc_t;

  // Offset counts lines from the start of the broadcast region
  typedef struct packed {
    logic [BC_OFF_W-1:0] offset;
    logic [31:0]         data;
  } bc_msg_t;

  typedef struct packed {
    logic [2:0]  addr;
    logic [31:0] data;
  } status_t;

endpackage

//--- src/core_cfg_pkg.sv
//////////////////////////////////////////////////
// Broadcast region must end at or below line 4096
//////////////////////////////////////////////////
package core_cfg_pkg;

  // Broadcast region at the top of packet memory
  localparam int BC_BASE_LINE = 3584;
  localparam int BC_LINES     = 512;

  // Core status addresses, 4 to 7 read as zero
  localparam logic [2:0] ST_DESC_CNT   = 3'd0;
  localparam logic [2:0] ST_WR_CNT     = 3'd1;
  localparam logic [2:0] ST_BC_IN_CNT  = 3'd2;
  localparam logic [2:0] ST_BC_OUT_CNT = 3'd3;

  localparam int ROUTE_ENTRIES = 8;

endpackage

//--- src/pipe_reg.sv
//////////////////////////////////////////////////
// REG_LENGTH must be 1 or more, one cycle per stage
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t  = logic,
  parameter int  REG_LENGTH = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t            dat [REG_LENGTH+1];
  logic [REG_LENGTH:0] vld;
  logic [REG_LENGTH:0] rdy;

  assign dat[0]          = s_data;
  assign vld[0]          = s_valid;
  assign s_ready         = rdy[0];
  assign m_data          = dat[REG_LENGTH];
  assign m_valid         = vld[REG_LENGTH];
  assign rdy[REG_LENGTH] = m_ready;

  for (genvar i = 0; i < REG_LENGTH; i++) begin : g_stage
    payload_t out_q;
    payload_t skid_q;
    logic     out_vld;
    logic     skid_vld;
    logic     take;
    logic     load;

    // Ready comes straight from a flop, so it does not ripple back
    assign rdy[i] = !skid_vld;
    assign take   = vld[i] && !skid_vld;
    assign load   = !out_vld || rdy[i+1];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        out_vld  <= 1'b0;
        skid_vld <= 1'b0;
      end else if (load) begin
        out_vld  <= skid_vld || take;
        skid_vld <= 1'b0;
      end else if (take) begin
        skid_vld <= 1'b1;
      end
    end

    // Skid entry catches the beat taken while the output stalls
    always_ff @(posedge clk) begin
      if (load) begin
        out_q <= skid_vld ? skid_q : dat[i];
      end else if (take) begin
        skid_q <= dat[i];
      end
    end

    assign dat[i+1] = out_q;
    assign vld[i+1] = out_vld;
  end

endmodule

//--- src/pkt_mem.sv
//////////////////////////////////////////////////
// Read during write to one line returns old data
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pkt_mem #(
  parameter int MEM_LINES = 4096
) (
  input  logic                                clk,
  input  logic                                wr_en,
  input  logic [core_region_pkg::LINE_AW-1:0] wr_addr,
  input  logic [core_region_pkg::DATA_W-1:0]  wr_data,
  input  logic [core_region_pkg::STRB_W-1:0]  wr_strb,
  input  logic                                rd_en,
  input  logic [core_region_pkg::LINE_AW-1:0] rd_addr,
  output logic [core_region_pkg::DATA_W-1:0]  rd_data
);
  import core_region_pkg::*;

  logic [DATA_W-1:0] mem [MEM_LINES];

  // Byte lanes written only where the strobe is set
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- src/desc_engine.sv
//////////////////////////////////////////////////
// Routing table has no reset, load it before use
//////////////////////////////////////////////////
`timescale 1ns/1ps

module desc_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [2:0]             route_addr,
  input  logic [3:0]             route_port,
  input  core_region_pkg::desc_t in_desc,
  input  logic                   in_valid,
  output logic                   in_taken,
  output core_region_pkg::desc_t out_desc,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [31:0]            desc_cnt
);
  import core_region_pkg::*;
  import core_cfg_pkg::*;

  logic [3:0] route [ROUTE_ENTRIES];
  desc_t      routed;

  // Status channel rewrites one entry every cycle
  always_ff @(posedge clk) begin
    route[route_addr] <= route_port;
  end

  always_comb begin
    routed      = in_desc;
    routed.port = route[in_desc.port[2:0]];
  end

  // Take a new descriptor only when the output slot frees up
  assign in_taken = in_valid && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      desc_cnt  <= '0;
    end else begin
      if (in_taken) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (out_valid && out_ready) begin
        desc_cnt <= desc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_taken) begin
      out_desc <= routed;
    end
  end

endmodule

//--- src/bc_msg_unit.sv
//////////////////////////////////////////////////
// Only the low 32 bits of a region line are shared
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bc_msg_unit #(
  parameter int BC_FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  core_region_pkg::dma_wr_cmd_t        wr_cmd,
  input  logic                                wr_fire,
  output logic                                bc_full,
  output core_region_pkg::bc_msg_t            bc_out,
  output logic                                bc_out_valid,
  input  logic                                bc_out_ready,
  input  core_region_pkg::bc_msg_t            bc_in,
  input  logic                                bc_in_valid,
  output logic                                bc_wr_en,
  output logic [core_region_pkg::LINE_AW-1:0] bc_wr_addr,
  output logic [core_region_pkg::DATA_W-1:0]  bc_wr_data,
  output logic [core_region_pkg::STRB_W-1:0]  bc_wr_strb,
  output logic [31:0]                         bc_in_cnt,
  output logic [31:0]                         bc_out_cnt
);
  import core_region_pkg::*;
  import core_cfg_pkg::*;

  localparam int PTR_W = (BC_FIFO_DEPTH > 1) ? $clog2(BC_FIFO_DEPTH) : 1;
  localparam logic [LINE_AW-1:0] BASE = LINE_AW'(BC_BASE_LINE);

  bc_msg_t            queue [BC_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic [LINE_AW-1:0] offset;
  logic               in_region;
  logic               push;
  logic               pop;

  ////////////////////////////////////////////////
  // Outgoing messages
  ////////////////////////////////////////////////
  assign offset    = wr_cmd.addr - BASE;
  assign in_region = (wr_cmd.addr >= BASE) && (offset < BC_LINES);

  // Blocks the pending DMA write, not just any write
  assign bc_full      = in_region && (count == (PTR_W+1)'(BC_FIFO_DEPTH));
  assign push         = wr_fire && in_region;
  assign pop          = bc_out_valid && bc_out_ready;
  assign bc_out_valid = (count != '0);
  assign bc_out       = queue[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      bc_in_cnt  <= '0;
      bc_out_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr     <= (rd_ptr == PTR_W'(BC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        bc_out_cnt <= bc_out_cnt + 1'b1;
      end
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
      if (bc_in_valid) begin
        bc_in_cnt <= bc_in_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= '{offset: offset[BC_OFF_W-1:0], data: wr_cmd.data[31:0]};
    end
  end

  ////////////////////////////////////////////////
  // Incoming messages
  ////////////////////////////////////////////////
  assign bc_wr_en   = bc_in_valid;
  assign bc_wr_addr = BASE + LINE_AW'(bc_in.offset);
  assign bc_wr_data = DATA_W'(bc_in.data);
  assign bc_wr_strb = STRB_W'(4'hF);

endmodule

//--- src/core_unit.sv
//////////////////////////////////////////////////
// Incoming broadcast always wins the write port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module core_unit #(
  parameter int MEM_LINES     = 4096,
  parameter int BC_FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          core_rst_n,
  // DMA channels
  input  core_region_pkg::dma_wr_cmd_t  wr_cmd,
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  core_region_pkg::dma_rd_cmd_t  rd_cmd,
  input  logic                          rd_valid,
  output logic                          rd_ready,
  output core_region_pkg::dma_rd_resp_t rd_resp,
  output logic                          rd_resp_valid,
  input  logic                          rd_resp_ready,
  // Descriptor channels
  input  core_region_pkg::desc_t        in_desc,
  input  logic                          in_valid,
  output logic                          in_taken,
  output core_region_pkg::desc_t        out_desc,
  output logic                          out_valid,
  input  logic                          out_ready,
  // Broadcast channels
  input  core_region_pkg::bc_msg_t      bc_in,
  input  logic                          bc_in_valid,
  output core_region_pkg::bc_msg_t      bc_out,
  output logic                          bc_out_valid,
  input  logic                          bc_out_ready,
  // Status channels
  input  core_region_pkg::status_t      wrapper_status,
  output core_region_pkg::status_t      core_status
);
  import core_region_pkg::*;
  import core_cfg_pkg::*;

  logic               wr_fire;
  logic               rd_fire;
  logic               desc_rst_n;
  logic               bc_full;
  logic               bc_wr_en;
  logic [LINE_AW-1:0] bc_wr_addr;
  logic [DATA_W-1:0]  bc_wr_data;
  logic [STRB_W-1:0]  bc_wr_strb;
  logic               mem_wr_en;
  logic [LINE_AW-1:0] mem_wr_addr;
  logic [DATA_W-1:0]  mem_wr_data;
  logic [STRB_W-1:0]  mem_wr_strb;
  logic [DATA_W-1:0]  rd_data;
  logic               rd_last_q;
  logic [31:0]        desc_cnt;
  logic [31:0]        wr_cnt;
  logic [31:0]        bc_in_cnt;
  logic [31:0]        bc_out_cnt;
  logic [2:0]         st_addr;

  ////////////////////////////////////////////////
  // Memory ports
  ////////////////////////////////////////////////
  assign wr_ready    = !bc_wr_en && !bc_full;
  assign wr_fire     = wr_valid && wr_ready;
  assign mem_wr_en   = bc_wr_en || wr_fire;
  assign mem_wr_addr = bc_wr_en ? bc_wr_addr : wr_cmd.addr;
  assign mem_wr_data = bc_wr_en ? bc_wr_data : wr_cmd.data;
  assign mem_wr_strb = bc_wr_en ? bc_wr_strb : wr_cmd.strb;

  // A held response keeps rd_data frozen since no new read fires
  assign rd_ready = !rd_resp_valid || rd_resp_ready;
  assign rd_fire  = rd_valid && rd_ready;
  assign rd_resp  = '{data: rd_data, last: rd_last_q};

  pkt_mem #(
    .MEM_LINES(MEM_LINES)
  ) u_mem (
    .clk, .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
    .wr_strb(mem_wr_strb), .rd_en(rd_fire), .rd_addr(rd_cmd.addr), .rd_data(rd_data)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_resp_valid <= 1'b0;
      wr_cnt        <= '0;
      st_addr       <= '0;
    end else begin
      if (rd_fire) begin
        rd_resp_valid <= 1'b1;
      end else if (rd_resp_ready) begin
        rd_resp_valid <= 1'b0;
      end
      if (wr_fire) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      st_addr <= st_addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_last_q <= rd_cmd.last;
    end
  end

  ////////////////////////////////////////////////
  // Descriptors and broadcast
  ////////////////////////////////////////////////
  assign desc_rst_n = rst_n && core_rst_n;

  desc_engine u_desc (
    .clk, .rst_n(desc_rst_n),
    .route_addr(wrapper_status.addr), .route_port(wrapper_status.data[3:0]),
    .in_desc, .in_valid, .in_taken, .out_desc, .out_valid, .out_ready, .desc_cnt
  );

  bc_msg_unit #(
    .BC_FIFO_DEPTH(BC_FIFO_DEPTH)
  ) u_bc (
    .clk, .rst_n, .wr_cmd, .wr_fire, .bc_full,
    .bc_out, .bc_out_valid, .bc_out_ready, .bc_in, .bc_in_valid,
    .bc_wr_en, .bc_wr_addr, .bc_wr_data, .bc_wr_strb, .bc_in_cnt, .bc_out_cnt
  );

  // Rotating status report, one address per cycle
  always_comb begin
    core_status.addr = st_addr;
    case (st_addr)
      ST_DESC_CNT:   core_status.data = desc_cnt;
      ST_WR_CNT:     core_status.data = wr_cnt;
      ST_BC_IN_CNT:  core_status.data = bc_in_cnt;
      ST_BC_OUT_CNT: core_status.data = bc_out_cnt;
      default:       core_status.data = '0;
    endcase
  end

endmodule

//--- src/core_region_wrap.sv
//////////////////////////////////////////////////
// Resets take one extra cycle; bc_in has no ready
//////////////////////////////////////////////////
`timescale 1ns/1ps

module core_region_wrap #(
  parameter int REG_LENGTH    = 1,
  parameter int MEM_LINES     = 4096,
  parameter int BC_FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          core_rst_n,
  input  core_region_pkg::dma_wr_cmd_t  wr_cmd,
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  core_region_pkg::dma_rd_cmd_t  rd_cmd,
  input  logic                          rd_valid,
  output logic                          rd_ready,
  output core_region_pkg::dma_rd_resp_t rd_resp,
  output logic                          rd_resp_valid,
  input  logic                          rd_resp_ready,
  input  core_region_pkg::desc_t        in_desc,
  input  logic                          in_valid,
  output logic                          in_taken,
  output core_region_pkg::desc_t        out_desc,
  output logic                          out_valid,
  input  logic                          out_ready,
  input  core_region_pkg::bc_msg_t      bc_in,
  input  logic                          bc_in_valid,
  output core_region_pkg::bc_msg_t      bc_out,
  output logic                          bc_out_valid,
  input  logic                          bc_out_ready,
  input  core_region_pkg::status_t      wrapper_status,
  output core_region_pkg::status_t      core_status
);
  import core_region_pkg::*;

  logic         rst_q;
  logic         core_rst_q;
  logic         desc_rst_n;
  dma_wr_cmd_t  wr_cmd_c;
  logic         wr_valid_c;
  logic         wr_ready_c;
  dma_rd_cmd_t  rd_cmd_c;
  logic         rd_valid_c;
  logic         rd_ready_c;
  dma_rd_resp_t rd_resp_c;
  logic         rd_resp_valid_c;
  logic         rd_resp_ready_c;
  desc_t        in_desc_c;
  logic         in_valid_c;
  logic         in_taken_c;
  desc_t        out_desc_c;
  logic         out_valid_c;
  logic         out_ready_c;
  bc_msg_t      bc_in_c;
  logic         bc_in_valid_c;
  bc_msg_t      bc_out_c;
  logic         bc_out_valid_c;
  logic         bc_out_ready_c;
  status_t      wrapper_status_q;
  status_t      core_status_c;

  ////////////////////////////////////////////////
  // Boundary registers
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    rst_q            <= rst_n;
    core_rst_q       <= core_rst_n;
    wrapper_status_q <= wrapper_status;
    core_status      <= core_status_c;
  end

  // Descriptor path also clears on the core reset
  assign desc_rst_n = rst_q && core_rst_q;

  pipe_reg #(.payload_t(dma_wr_cmd_t), .REG_LENGTH(REG_LENGTH)) u_wr_reg (
    .clk, .rst_n(rst_q),
    .s_data(wr_cmd), .s_valid(wr_valid), .s_ready(wr_ready),
    .m_data(wr_cmd_c), .m_valid(wr_valid_c), .m_ready(wr_ready_c)
  );

  pipe_reg #(.payload_t(dma_rd_cmd_t), .REG_LENGTH(REG_LENGTH)) u_rd_reg (
    .clk, .rst_n(rst_q),
    .s_data(rd_cmd), .s_valid(rd_valid), .s_ready(rd_ready),
    .m_data(rd_cmd_c), .m_valid(rd_valid_c), .m_ready(rd_ready_c)
  );

  pipe_reg #(.payload_t(dma_rd_resp_t), .REG_LENGTH(REG_LENGTH)) u_rd_resp_reg (
    .clk, .rst_n(rst_q),
    .s_data(rd_resp_c), .s_valid(rd_resp_valid_c), .s_ready(rd_resp_ready_c),
    .m_data(rd_resp), .m_valid(rd_resp_valid), .m_ready(rd_resp_ready)
  );

  pipe_reg #(.payload_t(desc_t), .REG_LENGTH(REG_LENGTH)) u_in_desc_reg (
    .clk, .rst_n(desc_rst_n),
    .s_data(in_desc), .s_valid(in_valid), .s_ready(in_taken),
    .m_data(in_desc_c), .m_valid(in_valid_c), .m_ready(in_taken_c)
  );

  pipe_reg #(.payload_t(desc_t), .REG_LENGTH(REG_LENGTH)) u_out_desc_reg (
    .clk, .rst_n(desc_rst_n),
    .s_data(out_desc_c), .s_valid(out_valid_c), .s_ready(out_ready_c),
    .m_data(out_desc), .m_valid(out_valid), .m_ready(out_ready)
  );

  // Broadcast input is never back-pressured
  pipe_reg #(.payload_t(bc_msg_t), .REG_LENGTH(REG_LENGTH)) u_bc_in_reg (
    .clk, .rst_n(rst_q),
    .s_data(bc_in), .s_valid(bc_in_valid), .s_ready(),
    .m_data(bc_in_c), .m_valid(bc_in_valid_c), .m_ready(1'b1)
  );

  pipe_reg #(.payload_t(bc_msg_t), .REG_LENGTH(REG_LENGTH)) u_bc_out_reg (
    .clk, .rst_n(rst_q),
    .s_data(bc_out_c), .s_valid(bc_out_valid_c), .s_ready(bc_out_ready_c),
    .m_data(bc_out), .m_valid(bc_out_valid), .m_ready(bc_out_ready)
  );

  ////////////////////////////////////////////////
  // Core
  ////////////////////////////////////////////////
  core_unit #(
    .MEM_LINES(MEM_LINES),
    .BC_FIFO_DEPTH(BC_FIFO_DEPTH)
  ) u_core (
    .clk, .rst_n(rst_q), .core_rst_n(core_rst_q),
    .wr_cmd(wr_cmd_c), .wr_valid(wr_valid_c), .wr_ready(wr_ready_c),
    .rd_cmd(rd_cmd_c), .rd_valid(rd_valid_c), .rd_ready(rd_ready_c),
    .rd_resp(rd_resp_c), .rd_resp_valid(rd_resp_valid_c), .rd_resp_ready(rd_resp_ready_c),
    .in_desc(in_desc_c), .in_valid(in_valid_c), .in_taken(in_taken_c),
    .out_desc(out_desc_c), .out_valid(out_valid_c), .out_ready(out_ready_c),
    .bc_in(bc_in_c), .bc_in_valid(bc_in_valid_c),
    .bc_out(bc_out_c), .bc_out_valid(bc_out_valid_c), .bc_out_ready(bc_out_ready_c),
    .wrapper_status(wrapper_status_q), .core_status(core_status_c)
  );

endmodule

//--- verification/core_region_props.sv
//////////////////////////////////////////////////
// Bound to every pipe_reg, checks the output side
//////////////////////////////////////////////////
`timescale 1ns/1ps

module core_region_props #(
  parameter int W = 1
) (
  input logic         clk,
  input logic         rst_n,
  input logic         m_valid,
  input logic         m_ready,
  input logic [W-1:0] m_data
);

  // A stalled beat stays offered
  a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid)
    else $error("pipe_reg dropped m_valid while stalled");

  // Payload does not move under back-pressure
  a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> $stable(m_data))
    else $error("pipe_reg changed m_data while stalled");

  a_reset_clear: assert property (@(posedge clk)
    !rst_n |=> !m_valid)
    else $error("pipe_reg m_valid high after reset");

endmodule

bind pipe_reg core_region_props #(.W($bits(m_data))) i_props (
  .clk, .rst_n, .m_valid, .m_ready, .m_data
);

//--- verification/core_region_wrap_tb.sv
//////////////////////////////////////////////////
// REG_LENGTH is set per build; lines are written before read
//////////////////////////////////////////////////
`timescale 1ns/1ps

module core_region_wrap_tb #(
  parameter int REG_LENGTH = 1
);
  import core_region_pkg::*;
  import core_cfg_pkg::*;

  localparam int MEM_LINES = 4096;
  localparam int TIMEOUT   = 500;
  localparam int N_LINES   = 12;
  localparam int N_DESC    = 16;

  logic         clk;
  logic         rst_n;
  logic         core_rst_n;
  dma_wr_cmd_t  wr_cmd;
  logic         wr_valid;
  logic         wr_ready;
  dma_rd_cmd_t  rd_cmd;
  logic         rd_valid;
  logic         rd_ready;
  dma_rd_resp_t rd_resp;
  logic         rd_resp_valid;
  logic         rd_resp_ready;
  desc_t        in_desc;
  logic         in_valid;
  logic         in_taken;
  desc_t        out_desc;
  logic         out_valid;
  logic         out_ready;
  bc_msg_t      bc_in;
  logic         bc_in_valid;
  bc_msg_t      bc_out;
  logic         bc_out_valid;
  logic         bc_out_ready;
  status_t      wrapper_status;
  status_t      core_status;

  integer            seed;
  int                err_cnt;
  int                to_cnt;
  int                n_wr;
  int                n_desc;
  int                n_bc_in;
  int                n_bc_out;
  logic [DATA_W-1:0] model [MEM_LINES];
  logic [3:0]        route_tbl [ROUTE_ENTRIES];

  core_region_wrap #(
    .REG_LENGTH(REG_LENGTH),
    .MEM_LINES(MEM_LINES),
    .BC_FIFO_DEPTH(4)
  ) i_core_region_wrap (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic report_timeout(input string what);
    to_cnt++;
    $display("Timeout while waiting for %s", what);
  endtask

  function automatic logic [DATA_W-1:0] rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic check_line(input string name, input dma_rd_resp_t got, input dma_rd_resp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_desc(input string name, input desc_t got, input desc_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_bc_msg(input string name, input bc_msg_t got, input bc_msg_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////
  // Channel drivers
  ////////////////////////////////////////////////
  task automatic write_line(input logic [LINE_AW-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
    int t;
    t = 0;
    wr_cmd   = '{addr: addr, data: data, strb: strb, last: 1'b1};
    wr_valid = 1'b1;
    while (!wr_ready && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (!wr_ready) report_timeout("DMA write ready");
    next_cycle();
    wr_valid = 1'b0;
    // Byte merge into the reference image
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        model[addr][8*b +: 8] = data[8*b +: 8];
      end
    end
    n_wr++;
  endtask

  task automatic send_rd(input logic [LINE_AW-1:0] addr, input logic last);
    int t;
    t = 0;
    rd_cmd   = '{addr: addr, last: last};
    rd_valid = 1'b1;
    while (!rd_ready && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (!rd_ready) report_timeout("DMA read ready");
    next_cycle();
    rd_valid = 1'b0;
  endtask

  task automatic collect_lines(input logic [LINE_AW-1:0] addrs [$]);
    int           got;
    int           t;
    dma_rd_resp_t exp;
    got = 0;
    t   = 0;
    while (got < addrs.size() && t < TIMEOUT) begin
      rd_resp_ready = ($random(seed) % 2) != 0;
      if (rd_resp_valid && rd_resp_ready) begin
        exp = '{data: model[addrs[got]], last: (got == addrs.size() - 1)};
        check_line("rd_resp", rd_resp, exp);
        got++;
      end
      next_cycle();
      t++;
    end
    if (got < addrs.size()) report_timeout("read responses");
    rd_resp_ready = 1'b0;
  endtask

  task automatic read_lines(input logic [LINE_AW-1:0] addrs [$]);
    fork
      begin
        foreach (addrs[i]) send_rd(addrs[i], i == addrs.size() - 1);
      end
      collect_lines(addrs);
    join
  endtask

  task automatic send_desc(input desc_t d);
    int t;
    t = 0;
    in_desc  = d;
    in_valid = 1'b1;
    while (!in_taken && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (!in_taken) report_timeout("descriptor input ready");
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic collect_desc(input desc_t sent [$]);
    int    got;
    int    t;
    desc_t exp;
    got = 0;
    t   = 0;
    while (got < sent.size() && t < TIMEOUT) begin
      out_ready = ($random(seed) % 2) != 0;
      if (out_valid && out_ready) begin
        exp      = sent[got];
        exp.port = route_tbl[sent[got].port[2:0]];
        check_desc("out_desc", out_desc, exp);
        got++;
      end
      next_cycle();
      t++;
    end
    if (got < sent.size()) report_timeout("routed descriptors");
    out_ready = 1'b0;
  endtask

  task automatic recv_bc(input bc_msg_t exp);
    int t;
    t = 0;
    bc_out_ready = 1'b1;
    while (!bc_out_valid && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (bc_out_valid) check_bc_msg("bc_out", bc_out, exp);
    else report_timeout("outgoing broadcast message");
    next_cycle();
    bc_out_ready = 1'b0;
    n_bc_out++;
  endtask

  // No ready on this channel, one beat per call
  task automatic send_bc_in(input bc_msg_t msg);
    bc_in       = msg;
    bc_in_valid = 1'b1;
    next_cycle();
    bc_in_valid = 1'b0;
    model[BC_BASE_LINE + int'(msg.offset)][31:0] = msg.data;
    n_bc_in++;
  endtask

  task automatic check_status_at(input logic [2:0] addr, input int exp_cnt);
    int      t;
    status_t exp;
    exp = '{addr: addr, data: 32'(exp_cnt)};
    t   = 0;
    // Go half a turn first so the sample is fresh
    while (core_status.addr != addr + 3'd4 && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    t = 0;
    while (core_status.addr != addr && t < TIMEOUT) begin
      next_cycle();
      t++;
    end
    if (core_status.addr == addr) check_status("core_status", core_status, exp);
    else report_timeout("status address");
  endtask

  ////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////
  task automatic dma_test();
    logic [LINE_AW-1:0] addrs [$];
    for (int i = 0; i < N_LINES; i++) begin
      addrs.push_back(LINE_AW'(i * 64 + ($random(seed) & 63)));
      write_line(addrs[i], rand_line(), '1);
    end
    for (int i = 0; i < N_LINES; i++) begin
      write_line(addrs[i], rand_line(), STRB_W'($random(seed)));
    end
    read_lines(addrs);
  endtask

  task automatic route_test();
    desc_t sent [$];
    for (int a = 0; a < ROUTE_ENTRIES; a++) begin
      route_tbl[a]   = 4'($random(seed));
      wrapper_status = '{addr: 3'(a), data: {28'd0, route_tbl[a]}};
      next_cycle();
    end
    for (int i = 0; i < N_DESC; i++) begin
      sent.push_back({$random(seed), $random(seed)});
    end
    fork
      begin
        foreach (sent[i]) send_desc(sent[i]);
      end
      collect_desc(sent);
    join
    n_desc += N_DESC;
  endtask

  task automatic bc_out_test();
    logic [DATA_W-1:0] d;
    d = rand_line();
    // Line just below the region, then the last region line
    write_line(LINE_AW'(BC_BASE_LINE - 1), rand_line(), '1);
    write_line(LINE_AW'(BC_BASE_LINE + BC_LINES - 1), d, '1);
    recv_bc('{offset: 9'(BC_LINES - 1), data: d[31:0]});
    if (bc_out_valid) begin
      err_cnt++;
      $display("Extra broadcast message after the region write");
    end
  endtask

  task automatic bc_in_test();
    logic [LINE_AW-1:0] addrs [$];
    logic [DATA_W-1:0]  d;
    d = rand_line();
    addrs.push_back(LINE_AW'(BC_BASE_LINE + 40));
    write_line(addrs[0], d, '1);
    recv_bc('{offset: 9'd40, data: d[31:0]});
    send_bc_in('{offset: 9'd40, data: $random(seed)});
    read_lines(addrs);
  endtask

  task automatic status_test();
    check_status_at(ST_DESC_CNT, n_desc);
    check_status_at(ST_WR_CNT, n_wr);
    check_status_at(ST_BC_IN_CNT, n_bc_in);
    check_status_at(ST_BC_OUT_CNT, n_bc_out);
    core_rst_n = 1'b0;
    next_cycle();
    core_rst_n = 1'b1;
    check_status_at(ST_DESC_CNT, 0);
    check_status_at(ST_WR_CNT, n_wr);
    check_status_at(ST_BC_IN_CNT, n_bc_in);
    check_status_at(ST_BC_OUT_CNT, n_bc_out);
  endtask

  initial begin
    seed           = 84914;
    err_cnt        = 0;
    to_cnt         = 0;
    n_wr           = 0;
    n_desc         = 0;
    n_bc_in        = 0;
    n_bc_out       = 0;
    rst_n          = 1'b0;
    core_rst_n     = 1'b1;
    wr_cmd         = '0;
    wr_valid       = 1'b0;
    rd_cmd         = '0;
    rd_valid       = 1'b0;
    rd_resp_ready  = 1'b0;
    in_desc        = '0;
    in_valid       = 1'b0;
    out_ready      = 1'b0;
    bc_in          = '0;
    bc_in_valid    = 1'b0;
    bc_out_ready   = 1'b0;
    wrapper_status = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Wrapper registers rst_n, so the slices leave reset one cycle later
    next_cycle();
    dma_test();
    route_test();
    bc_out_test();
    bc_in_test();
    status_test();
    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- core_region_wrap.f
src/core_region_pkg.sv
src/core_cfg_pkg.sv
src/pipe_reg.sv
src/pkt_mem.sv
src/desc_engine.sv
src/bc_msg_unit.sv
src/core_unit.sv
src/core_region_wrap.sv
verification/core_region_props.sv
verification/core_region_wrap_tb.sv

//--- Makefile
# Verilator run of the core region testbench with REG_LENGTH 1 and 2
TOP = core_region_wrap_tb

.PHONY: all lint clean

all:
	for n in 1 2; do \
	  verilator --binary --timing --assert -Wno-fatal -GREG_LENGTH=$$n \
	    --top-module $(TOP) --Mdir obj_dir_$$n -f core_region_wrap.f || exit 1; \
	  out=$$(./obj_dir_$$n/V$(TOP)); echo "$$out"; \
	  echo "$$out" | grep -q "ALL CHECKS PASSED" || exit 1; \
	done

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f core_region_wrap.f

clean:
	rm -rf obj_dir_1 obj_dir_2
